/* verilog.f */
+incdir+verilog
verilog/test_io_req_pkg.sv
verilog/test_io_link_pkg.sv
verilog/test_io_req_arb.sv
verilog/test_io_req_proc.sv
verilog/test_io_shifter.sv
verilog/test_io_target.sv
verilog/test_io_top.sv
test/tb_test_io_top.sv

/* test/tb_test_io_top.sv */
// Random traffic on both ports; uses 16 low addresses, all of them written before any read
`timescale 1ns/1ps
`include "test_io_params.svh"

module tb_test_io_top
    import test_io_req_pkg::*;
();

localparam int     N_DIRECT    = 16;
localparam int     N_RANDOM    = 60;
localparam int     TOTAL_REQS  = 3 * N_DIRECT + 2 * N_RANDOM;
// Worst read takes about 112 cycles and the rest covers response stalls
localparam int     REQ_CYCLES  = 200;
localparam longint WATCHDOG_NS = longint'(TOTAL_REQS * REQ_CYCLES + 1000) * 20;

logic                   clk;
logic                   rst_n;
logic [1:0]             req_vld;
logic [1:0]             req_rdy;
tio_req_t [1:0]         req;
logic [1:0]             rd_resp_vld;
logic [1:0]             rd_resp_rdy;
tio_rd_resp_t [1:0]     rd_resp;

logic [31:0]            rng_state;
logic [`TIO_DATA_W-1:0] mem_model [0:(1<<`TIO_MEM_AW)-1];
tio_req_t               issue_q0 [$];
tio_req_t               issue_q1 [$];
logic [`TIO_DATA_W-1:0] exp_q0 [$];
logic [`TIO_DATA_W-1:0] exp_q1 [$];
logic [`TIO_DATA_W-1:0] held_data [0:1];
logic [1:0]             held;
logic                   last_port;
logic                   random_mode;
int                     err_count;
int                     check_count;

test_io_top UUT (
     .clk (clk), .rst_n (rst_n)
    ,.req_vld (req_vld), .req_rdy (req_rdy), .req (req)
    ,.rd_resp_vld (rd_resp_vld), .rd_resp_rdy (rd_resp_rdy), .rd_resp (rd_resp)
);

// ======================================================================
// Helpers
// ======================================================================
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// Low byte is k*17, so all eight address bits toggle
function automatic logic [`TIO_ADDR_W-1:0] pick_addr();
    logic [31:0]            r;
    logic [`TIO_ADDR_W-1:0] a;
    r = next_rand();
    a = '0;
    a[`TIO_MEM_AW-1:0] = 8'(r[3:0]) * 8'd17;
    if (r[6:4] == 3'd0) begin
        a[`TIO_ADDR_W-1:`TIO_MEM_AW] = next_rand() | 32'h1;
    end
    return a;
endfunction

function automatic tio_req_t random_request();
    tio_req_t r;
    r.op   = 2'(next_rand());
    r.addr = pick_addr();
    r.data = {next_rand(), next_rand()};
    return r;
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
        $display("mismatch %s: got %h expected %h", name, got, exp);
        err_count++;
    end
endtask

task automatic report_error(input string msg);
    $display("error: %s at %0t", msg, $time);
    err_count++;
endtask

task automatic print_summary();
    $display("checks %0d, errors %0d", check_count, err_count);
endtask

// Model update at acceptance; reads get their expected word here
task automatic record_request(input int p, input tio_req_t r);
    logic                   in_range;
    logic [`TIO_DATA_W-1:0] exp_data;
    in_range = (r.addr[`TIO_ADDR_W-1:`TIO_MEM_AW] == '0);
    if (r.op[0]) begin
        if (in_range) begin
            mem_model[r.addr[`TIO_MEM_AW-1:0]] = r.data;
        end
    end
    else begin
        exp_data = in_range ? mem_model[r.addr[`TIO_MEM_AW-1:0]] : '0;
        if (p == 0) begin
            exp_q0.push_back(exp_data);
        end
        else begin
            exp_q1.push_back(exp_data);
        end
    end
endtask

// ======================================================================
// Per-cycle sampling at the falling edge and driving after the rise
// ======================================================================
task automatic observe_cycle(output logic [1:0] acc);
    logic [1:0]             fire;
    logic                   exp_port;
    logic [`TIO_DATA_W-1:0] exp_data;
    int                     p;
    acc  = req_vld & req_rdy;
    fire = rd_resp_vld & rd_resp_rdy;
    if (acc == 2'b11) begin
        report_error("both ports accepted in the same cycle");
    end
    if (rd_resp_vld != 2'b00 && req_rdy != 2'b00) begin
        report_error("request accepted while a read response is pending");
    end
    if (rd_resp_vld == 2'b11) begin
        report_error("read response presented on both ports");
    end
    for (p = 0; p < 2; p++) begin
        if (acc[p]) begin
            if (req_vld == 2'b11) begin
                exp_port = ~last_port;
                check_value("grant_port", 64'(p), 64'(exp_port));
            end
            last_port = p[0];
            record_request(p, req[p]);
        end
        if (held[p]) begin
            if (!rd_resp_vld[p]) begin
                report_error("read response withdrawn before it was taken");
            end
            else begin
                check_value("rd_resp_hold", rd_resp[p].data, held_data[p]);
            end
        end
        if (fire[p]) begin
            if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0)) begin
                report_error($sformatf("read response on port %0d with no read issued", p));
            end
            else begin
                exp_data = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
                check_value(p == 0 ? "rd_resp0" : "rd_resp1", rd_resp[p].data, exp_data);
            end
        end
        held[p]      = rd_resp_vld[p] & ~rd_resp_rdy[p];
        held_data[p] = rd_resp[p].data;
    end
endtask

task automatic drive_ports(input logic [1:0] acc);
    logic [31:0] r;
    int          p;
    for (p = 0; p < 2; p++) begin
        r = next_rand();
        if (acc[p] || !req_vld[p]) begin
            req_vld[p] = 1'b0;
            if (r[1:0] != 2'd0 || !random_mode) begin
                if (p == 0 && issue_q0.size() > 0) begin
                    req[0]     = issue_q0.pop_front();
                    req_vld[0] = 1'b1;
                end
                else if (p == 1 && issue_q1.size() > 0) begin
                    req[1]     = issue_q1.pop_front();
                    req_vld[1] = 1'b1;
                end
            end
        end
        rd_resp_rdy[p] = random_mode ? (r[3:2] != 2'd0) : 1'b1;
    end
endtask

task automatic run_phase();
    logic [1:0] acc;
    logic       busy;
    busy = 1'b1;
    while (busy) begin
        @(negedge clk);
        observe_cycle(acc);
        @(posedge clk);
        #2;
        drive_ports(acc);
        busy = (issue_q0.size() > 0) || (issue_q1.size() > 0) || (req_vld != 2'b00)
            || (exp_q0.size() > 0) || (exp_q1.size() > 0);
    end
endtask

// ======================================================================
// Clock, watchdog and test sequence
// ======================================================================
initial begin
    clk = 1'b0;
    forever begin
        #10 clk = ~clk;
    end
end

initial begin
    #(WATCHDOG_NS);
    report_error("watchdog expired, the DUT stopped making progress");
    print_summary();
    $display("Some tests failed");
    $finish;
end

initial begin
    tio_req_t r;
    int       k;
    rst_n       = 1'b0;
    req_vld     = 2'b00;
    req         = '0;
    rd_resp_rdy = 2'b11;
    rng_state   = 32'h1548;
    held        = 2'b00;
    last_port   = 1'b1;
    random_mode = 1'b0;
    err_count   = 0;
    check_count = 0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Quiet after reset
    repeat (3) begin
        @(negedge clk);
        check_value("rd_resp_vld", 64'(rd_resp_vld), 64'h0);
        check_value("req_rdy", 64'(req_rdy), 64'h0);
    end
    @(posedge clk);
    #2;

    // Port 0 fills every address the test uses
    for (k = 0; k < N_DIRECT; k++) begin
        r.op   = 2'd1;
        r.addr = 40'(k * 17);
        r.data = {next_rand(), next_rand()};
        issue_q0.push_back(r);
    end
    run_phase();

    // Port 1 reads back the low address of the previous dropped write on port 0
    for (k = 0; k < N_DIRECT; k++) begin
        r.op   = 2'd1;
        r.addr = {32'h1 << k, 8'(k * 17)};
        r.data = {next_rand(), next_rand()};
        issue_q0.push_back(r);
        r.op   = 2'd0;
        r.addr = 40'(((k + N_DIRECT - 1) % N_DIRECT) * 17);
        issue_q1.push_back(r);
    end
    run_phase();

    random_mode = 1'b1;
    for (k = 0; k < N_RANDOM; k++) begin
        issue_q0.push_back(random_request());
        issue_q1.push_back(random_request());
    end
    run_phase();

    print_summary();
    if (err_count == 0) begin
        $display("All tests passed");
    end
    else begin
        $display("Some tests failed");
    end
    $finish;
end

endmodule

/* verilog/test_io_top.sv */
// Both link ends in one clock domain; serial lines stay internal to this level
`timescale 1ns/1ps
`include "test_io_params.svh"

module test_io_top
    import test_io_req_pkg::*;
    import test_io_link_pkg::*;
(
     input  logic               clk
    ,input  logic               rst_n
    ,input  logic [1:0]         req_vld
    ,output logic [1:0]         req_rdy
    ,input  tio_req_t [1:0]     req
    ,output logic [1:0]         rd_resp_vld
    ,input  logic [1:0]         rd_resp_rdy
    ,output tio_rd_resp_t [1:0] rd_resp
);

logic                   proc_req_vld;
logic                   proc_req_rdy;
tio_req_t               proc_req;
logic                   proc_rd_resp_vld;
logic                   proc_rd_resp_rdy;
tio_rd_resp_t           proc_rd_resp;
logic                   start;
tio_frame_u             frame;
logic [7:0]             frame_size;
logic                   done;
logic [`TIO_DATA_W-1:0] resp_word;
logic                   link_eoen;
logic                   link_eout;
logic                   link_mdata;
logic                   link_doen;
logic                   link_tdata;

test_io_req_arb u_arb (
     .clk (clk), .rst_n (rst_n)
    ,.req_vld (req_vld), .req_rdy (req_rdy), .req (req)
    ,.rd_resp_vld (rd_resp_vld), .rd_resp_rdy (rd_resp_rdy), .rd_resp (rd_resp)
    ,.proc_req_vld (proc_req_vld), .proc_req_rdy (proc_req_rdy), .proc_req (proc_req)
    ,.proc_rd_resp_vld (proc_rd_resp_vld), .proc_rd_resp_rdy (proc_rd_resp_rdy)
    ,.proc_rd_resp (proc_rd_resp)
);

test_io_req_proc u_proc (
     .clk (clk), .rst_n (rst_n)
    ,.req_vld (proc_req_vld), .req_rdy (proc_req_rdy), .req (proc_req)
    ,.rd_resp_vld (proc_rd_resp_vld), .rd_resp_rdy (proc_rd_resp_rdy)
    ,.rd_resp (proc_rd_resp)
    ,.start (start), .frame (frame), .frame_size (frame_size)
    ,.done (done), .resp_word (resp_word)
);

// Master data enable equals eoen on this link, so it stays open
test_io_shifter u_shifter (
     .clk (clk), .rst_n (rst_n)
    ,.start (start), .frame (frame), .frame_size (frame_size)
    ,.done (done), .resp_word (resp_word)
    ,.eoen (link_eoen), .eout (link_eout), .ein (link_doen)
    ,.doen (), .dout (link_mdata), .din (link_tdata)
);

test_io_target u_target (
     .clk (clk), .rst_n (rst_n)
    ,.eoen (link_eoen), .eout (link_eout)
    ,.doen (link_doen), .dout (link_tdata), .din (link_mdata)
);

endmodule

/* verilog/test_io_target.sv */
// Link target with 2**TIO_MEM_AW words; out-of-range reads give zero and writes are dropped
`timescale 1ns/1ps
`include "test_io_params.svh"

module test_io_target
    import test_io_link_pkg::*;
(
     input  logic clk
    ,input  logic rst_n
    ,input  logic eoen
    ,input  logic eout
    ,output logic doen
    ,output logic dout
    ,input  logic din
);

localparam logic [1:0] ST_IDLE = 2'd0,
                       ST_TURN = 2'd1,
                       ST_TX   = 2'd2;
localparam int CNT_W = $clog2(`TIO_FRAME_W + 1);

logic [1:0]              st;
logic [`TIO_FRAME_W-1:0] rx_bits;
tio_frame_u              rx_frame;
logic [CNT_W-1:0]        rx_cnt;
logic [3:0]              turn_cnt;
logic [CNT_W-1:0]        tx_cnt;
logic [`TIO_DATA_W-1:0]  tx_word;
logic                    frame_end;
logic                    is_wr;
logic                    wr_in_range;
logic                    rd_in_range;
logic [`TIO_DATA_W-1:0]  mem [0:(1<<`TIO_MEM_AW)-1];

assign rx_frame  = rx_bits;
assign frame_end = (st == ST_IDLE) && !eoen && (rx_cnt != '0);
assign is_wr     = rx_frame.wr.op[0];

assign wr_in_range = (rx_frame.wr.addr[`TIO_ADDR_W-1:`TIO_MEM_AW] == '0);
assign rd_in_range = (rx_frame.rd.addr[`TIO_ADDR_W-1:`TIO_MEM_AW] == '0);

assign doen = (st == ST_TX);
assign dout = (st == ST_TX) & tx_word[`TIO_DATA_W-1];

// Bits land MSB aligned, so a short read frame leaves op in the top bits
always_ff @(posedge clk) begin
    if (st == ST_IDLE && eoen) begin
        rx_bits[`TIO_FRAME_W-1-rx_cnt] <= din;
    end
end

// ======================================================================
// Memory access and response word
// ======================================================================
always_ff @(posedge clk) begin
    if (frame_end) begin
        if (is_wr) begin
            if (wr_in_range) begin
                mem[rx_frame.wr.addr[`TIO_MEM_AW-1:0]] <= rx_frame.wr.data;
            end
            // Ack goes out as the single MSB
            tx_word <= {wr_in_range, {(`TIO_DATA_W-1){1'b0}}};
        end
        else begin
            tx_word <= rd_in_range ? mem[rx_frame.rd.addr[`TIO_MEM_AW-1:0]] : '0;
        end
    end
    else if (st == ST_TX) begin
        tx_word <= tx_word << 1;
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        st       <= ST_IDLE;
        rx_cnt   <= '0;
        turn_cnt <= '0;
        tx_cnt   <= '0;
    end
    else begin
        case (st)
            ST_IDLE: begin
                if (eoen) begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
                else if (rx_cnt != '0) begin
                    // Decode cycle counts as the first turnaround cycle
                    rx_cnt   <= '0;
                    turn_cnt <= 4'(`TIO_TURN - 1);
                    tx_cnt   <= is_wr ? CNT_W'(1) : CNT_W'(`TIO_DATA_W);
                    st       <= ST_TURN;
                end
            end
            ST_TURN: begin
                turn_cnt <= turn_cnt - 4'd1;
                if (turn_cnt == 4'd1) begin
                    st <= ST_TX;
                end
            end
            ST_TX: begin
                tx_cnt <= tx_cnt - 1'b1;
                if (tx_cnt == CNT_W'(1)) begin
                    st <= ST_IDLE;
                end
            end
            default: st <= ST_IDLE;
        endcase
    end
end

a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
    frame_end |-> rx_cnt == (is_wr ? CNT_W'(`TIO_WR_FRAME_BITS) : CNT_W'(`TIO_RD_FRAME_BITS)));

a_marker_match: assert property (@(posedge clk) disable iff (!rst_n)
    eout == eoen);

endmodule

/* verilog/test_io_shifter.sv */
// Link master; sends MSB first and expects the target to hold its lines low during the frame
`timescale 1ns/1ps
`include "test_io_params.svh"

module test_io_shifter
    import test_io_link_pkg::*;
(
     input  logic                   clk
    ,input  logic                   rst_n
    ,input  logic                   start
    ,input  tio_frame_u             frame
    ,input  logic [7:0]             frame_size
    ,output logic                   done
    ,output logic [`TIO_DATA_W-1:0] resp_word
    ,output logic                   eoen
    ,output logic                   eout
    ,input  logic                   ein
    ,output logic                   doen
    ,output logic                   dout
    ,input  logic                   din
);

localparam logic [1:0] ST_IDLE = 2'd0,
                       ST_SEND = 2'd1,
                       ST_RECV = 2'd2;

logic [1:0]              st;
logic [`TIO_FRAME_W-1:0] tx_sreg;
logic [7:0]              bit_cnt;
logic                    ein_q;
logic                    sending;

assign sending = (st == ST_SEND);

// Frame marker and data ownership both span the frame
assign eoen = sending;
assign eout = sending;
assign doen = sending;
assign dout = sending & tx_sreg[`TIO_FRAME_W-1];

// Target enable just fell, last response bit was the previous cycle
assign done = (st == ST_RECV) & ein_q & ~ein;

// ======================================================================
// Control
// ======================================================================
always_ff @(posedge clk) begin
    if (!rst_n) begin
        st      <= ST_IDLE;
        bit_cnt <= '0;
        ein_q   <= 1'b0;
    end
    else begin
        ein_q <= ein;
        case (st)
            ST_IDLE: begin
                if (start) begin
                    bit_cnt <= frame_size;
                    st      <= ST_SEND;
                end
            end
            ST_SEND: begin
                bit_cnt <= bit_cnt - 8'd1;
                if (bit_cnt == 8'd1) begin
                    st <= ST_RECV;
                end
            end
            ST_RECV: begin
                if (done) begin
                    st <= ST_IDLE;
                end
            end
            default: st <= ST_IDLE;
        endcase
    end
end

// ======================================================================
// Data path
// ======================================================================
always_ff @(posedge clk) begin
    if (start) begin
        tx_sreg <= frame;
    end
    else if (sending) begin
        tx_sreg <= tx_sreg << 1;
    end
end

// Cleared at start so a write ack lands in bit 0
always_ff @(posedge clk) begin
    if (start) begin
        resp_word <= '0;
    end
    else if (st == ST_RECV && ein) begin
        resp_word <= {resp_word[`TIO_DATA_W-2:0], din};
    end
end

a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> st == ST_IDLE);

// Target may only turn the link around after the frame
a_turnaround: assert property (@(posedge clk) disable iff (!rst_n)
    ein |-> st == ST_RECV);

endmodule

/* verilog/test_io_req_proc.sv */
// One request at a time; a held read response stalls the link and blocks new requests
`timescale 1ns/1ps
`include "test_io_params.svh"

module test_io_req_proc
    import test_io_req_pkg::*;
    import test_io_link_pkg::*;
(
     input  logic                   clk
    ,input  logic                   rst_n
    ,input  logic                   req_vld
    ,output logic                   req_rdy
    ,input  tio_req_t               req
    ,output logic                   rd_resp_vld
    ,input  logic                   rd_resp_rdy
    ,output tio_rd_resp_t           rd_resp
    ,output logic                   start
    ,output tio_frame_u             frame
    ,output logic [7:0]             frame_size
    ,input  logic                   done
    ,input  logic [`TIO_DATA_W-1:0] resp_word
);

localparam logic [2:0] ST_IDLE    = 3'd0,
                       ST_WR_SEND = 3'd1,
                       ST_WR_WAIT = 3'd2,
                       ST_RD_SEND = 3'd3,
                       ST_RD_WAIT = 3'd4,
                       ST_RD_HOLD = 3'd5;

logic [2:0]  st;
logic [2:0]  st_nxt;
tio_frame_u  frame_q;
logic [7:0]  size_q;

assign frame        = frame_q;
assign frame_size   = size_q;
// Shifter keeps resp_word until the next start
assign rd_resp.data = resp_word;

// ======================================================================
// Frame build at acceptance
// ======================================================================
always_ff @(posedge clk) begin
    if (req_vld && req_rdy) begin
        if (req.op[0]) begin
            frame_q.wr.op   <= TIO_OP_WR;
            frame_q.wr.addr <= req.addr;
            frame_q.wr.data <= req.data;
            size_q          <= 8'(`TIO_WR_FRAME_BITS);
        end
        else begin
            frame_q.rd.op     <= TIO_OP_RD;
            frame_q.rd.addr   <= req.addr;
            frame_q.rd.unused <= '0;
            size_q            <= 8'(`TIO_RD_FRAME_BITS);
        end
    end
end

// ======================================================================
// Control FSM
// ======================================================================
always_ff @(posedge clk) begin
    if (!rst_n) begin
        st <= ST_IDLE;
    end
    else begin
        st <= st_nxt;
    end
end

always_comb begin
    st_nxt      = st;
    req_rdy     = 1'b0;
    start       = 1'b0;
    rd_resp_vld = 1'b0;
    case (st)
        ST_IDLE: begin
            req_rdy = 1'b1;
            if (req_vld) begin
                st_nxt = req.op[0] ? ST_WR_SEND : ST_RD_SEND;
            end
        end
        ST_WR_SEND: begin
            start  = 1'b1;
            st_nxt = ST_WR_WAIT;
        end
        ST_WR_WAIT: begin
            // Ack bit only marks completion
            if (done) begin
                st_nxt = ST_IDLE;
            end
        end
        ST_RD_SEND: begin
            start  = 1'b1;
            st_nxt = ST_RD_WAIT;
        end
        ST_RD_WAIT: begin
            if (done) begin
                rd_resp_vld = 1'b1;
                st_nxt      = rd_resp_rdy ? ST_IDLE : ST_RD_HOLD;
            end
        end
        ST_RD_HOLD: begin
            rd_resp_vld = 1'b1;
            if (rd_resp_rdy) begin
                st_nxt = ST_IDLE;
            end
        end
        default: st_nxt = ST_IDLE;
    endcase
end

a_done_when_waiting: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (st == ST_WR_WAIT || st == ST_RD_WAIT));

a_resp_held: assert property (@(posedge clk) disable iff (!rst_n)
    rd_resp_vld && !rd_resp_rdy |=> rd_resp_vld && $stable(rd_resp));

endmodule

/* verilog/test_io_req_arb.sv */
// Two-port round-robin arbiter; assumes at most one read outstanding at the processor
`timescale 1ns/1ps
`include "test_io_params.svh"

module test_io_req_arb
    import test_io_req_pkg::*;
(
     input  logic                   clk
    ,input  logic                   rst_n
    ,input  logic [1:0]             req_vld
    ,output logic [1:0]             req_rdy
    ,input  tio_req_t [1:0]         req
    ,output logic [1:0]             rd_resp_vld
    ,input  logic [1:0]             rd_resp_rdy
    ,output tio_rd_resp_t [1:0]     rd_resp
    ,output logic                   proc_req_vld
    ,input  logic                   proc_req_rdy
    ,output tio_req_t               proc_req
    ,input  logic                   proc_rd_resp_vld
    ,output logic                   proc_rd_resp_rdy
    ,input  tio_rd_resp_t           proc_rd_resp
);

logic [1:0] gnt;
logic       rr_ptr;
logic       rd_owner;
logic       rd_pend;
logic       req_fire;
logic       resp_fire;

// Pointer names the favoured port, the other wins only when it is alone
assign gnt[0] = req_vld[0] & (~rr_ptr | ~req_vld[1]);
assign gnt[1] = req_vld[1] & ( rr_ptr | ~req_vld[0]);

assign proc_req_vld = |req_vld;
assign proc_req     = gnt[1] ? req[1] : req[0];
assign req_rdy      = gnt & {2{proc_req_rdy}};
assign req_fire     = proc_req_vld & proc_req_rdy;

// Response handshake goes to the owner of the read only
assign rd_resp_vld[0]   = proc_rd_resp_vld & ~rd_owner;
assign rd_resp_vld[1]   = proc_rd_resp_vld &  rd_owner;
assign rd_resp[0]       = proc_rd_resp;
assign rd_resp[1]       = proc_rd_resp;
assign proc_rd_resp_rdy = rd_resp_rdy[rd_owner];
assign resp_fire        = proc_rd_resp_vld & proc_rd_resp_rdy;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        rr_ptr   <= 1'b0;
        rd_owner <= 1'b0;
        rd_pend  <= 1'b0;
    end
    else begin
        if (resp_fire) begin
            rd_pend <= 1'b0;
        end
        if (req_fire) begin
            // Move past the winner
            rr_ptr <= gnt[0];
            if (!proc_req.op[0]) begin
                rd_owner <= gnt[1];
                rd_pend  <= 1'b1;
            end
        end
    end
end

a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    proc_req_vld |-> $onehot(gnt));

a_resp_has_owner: assert property (@(posedge clk) disable iff (!rst_n)
    proc_rd_resp_vld |-> rd_pend);

endmodule

/* verilog/test_io_link_pkg.sv */
// Serial link frame types; op sits in the top bits and is sent first
`include "test_io_params.svh"

package test_io_link_pkg;

    typedef enum logic [`TIO_OP_W-1:0] {
        TIO_OP_RD = 2'd0,
        TIO_OP_WR = 2'd1
    } tio_op_e;

    // Write view, all 106 bits go on the wire
    typedef struct packed {
        tio_op_e                op;
        logic [`TIO_ADDR_W-1:0] addr;
        logic [`TIO_DATA_W-1:0] data;
    } tio_wr_view_t;

    // Read view, only op and addr are sent
    typedef struct packed {
        tio_op_e                op;
        logic [`TIO_ADDR_W-1:0] addr;
        logic [`TIO_DATA_W-1:0] unused;
    } tio_rd_view_t;

    typedef union packed {
        tio_wr_view_t wr;
        tio_rd_view_t rd;
    } tio_frame_u;

endpackage

/* verilog/test_io_req_pkg.sv */
// Requester-side types; op travels raw and only its bit 0 selects a write
`include "test_io_params.svh"

package test_io_req_pkg;

    // ======================================================================
    // Request from a requester port, also the arbiter output
    // ======================================================================

    // Op 1 is a write, op 0 is a read
    typedef struct packed {
        logic [`TIO_OP_W-1:0]   op;
        logic [`TIO_ADDR_W-1:0] addr;
        logic [`TIO_DATA_W-1:0] data;
    } tio_req_t;

    // ======================================================================
    // Read response back to the requester
    // ======================================================================

    // Zero when the address was out of the target's range
    typedef struct packed {
        logic [`TIO_DATA_W-1:0] data;
    } tio_rd_resp_t;

endpackage

/* verilog/test_io_params.svh */
// Fixed link protocol widths; TIO_TURN must be at least 2 and memory depth is 2**TIO_MEM_AW words
`ifndef TEST_IO_PARAMS_SVH
`define TEST_IO_PARAMS_SVH

// Field widths on both the requester side and the link
`define TIO_OP_W            2
`define TIO_ADDR_W          40
`define TIO_DATA_W          64

// Full frame word, write view and read view share it
`define TIO_FRAME_W         (`TIO_OP_W + `TIO_ADDR_W + `TIO_DATA_W)

// Bits shifted out per op
`define TIO_WR_FRAME_BITS   (`TIO_OP_W + `TIO_ADDR_W + `TIO_DATA_W)
`define TIO_RD_FRAME_BITS   (`TIO_OP_W + `TIO_ADDR_W)

// Target memory and link turnaround
`define TIO_MEM_AW          8
`define TIO_TURN            2

`endif
